// File: Bender.yml
package:
  name: frontend_dispatch

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fe_pkg.sv
      - rtl/queue_ptr.sv
      - rtl/inst_decode.sv
      - rtl/disp_select.sv
      - rtl/inst_buffer.sv
      - rtl/frontend_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_frontend.sv

// File: rtl/disp_select.sv
`timescale 1ns/1ns
`include "fe_cfg.svh"

module disp_select (
  input  logic [`FE_DISP_SIZE-1:0] i_slot_vld,
  input  fe_pkg::inst_cat_t        i_cat [`FE_DISP_SIZE],
  output logic [`FE_DISP_SIZE-1:0] o_disp_mask
);
  localparam int CNT_W = $clog2(`FE_DISP_SIZE + 1);

  logic [`FE_DISP_SIZE-1:0] w_over;  // slot breaks a quota

  // running class counts, slot k sees slots 0..k
  always_comb begin
    logic [CNT_W-1:0] arith_cnt;
    logic [CNT_W-1:0] mem_cnt;
    logic [CNT_W-1:0] bru_cnt;
    arith_cnt = '0;
    mem_cnt   = '0;
    bru_cnt   = '0;
    for (int k = 0; k < `FE_DISP_SIZE; k++) begin
      case (i_cat[k])
        fe_pkg::LD, fe_pkg::ST: mem_cnt   = mem_cnt + 1'b1;
        fe_pkg::BR:             bru_cnt   = bru_cnt + 1'b1;
        default:                arith_cnt = arith_cnt + 1'b1;  // illegal too
      endcase
      w_over[k] = (arith_cnt > `FE_ARITH_QUOTA) ||
                  (mem_cnt > `FE_MEM_QUOTA) ||
                  (bru_cnt > `FE_BRU_QUOTA);
    end
  end

  always_comb begin
    o_disp_mask[0] = i_slot_vld[0] & ~w_over[0];
    for (int k = 1; k < `FE_DISP_SIZE; k++) begin
      o_disp_mask[k] = o_disp_mask[k-1] & i_slot_vld[k] & ~w_over[k];
    end
  end

  // group is always slots 0..n-1 and only over valid words
  a_prefix : assert property (@(o_disp_mask)
    ((o_disp_mask & (o_disp_mask + 1'b1)) == '0) &&
    ((o_disp_mask & ~i_slot_vld) == '0));

endmodule

// File: rtl/fe_cfg.svh
`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// fetch side
`define FE_FETCH_WORDS 4
`define FE_VADDR_W     32

// blocks held in the instruction buffer
`define FE_BUF_SIZE    4

// dispatch side
`define FE_DISP_SIZE   4

// per-group class limits
`define FE_ARITH_QUOTA 2
`define FE_MEM_QUOTA   1
`define FE_BRU_QUOTA   1

`endif

// File: rtl/fe_pkg.sv
`include "fe_cfg.svh"

package fe_pkg;

  typedef enum logic [2:0] {
    ARITH   = 3'd0,
    LD      = 3'd1,
    ST      = 3'd2,
    BR      = 3'd3,
    ILLEGAL = 3'd4
  } inst_cat_t;

  // aligned block from fetch, word 0 in the low data bits
  typedef struct packed {
    logic [`FE_VADDR_W-1:2]        addr;  // word address of word 0
    logic [`FE_FETCH_WORDS*32-1:0] data;
  } fetch_blk_t;

  typedef struct packed {
    logic                   valid;
    logic [31:0]            inst;
    logic [`FE_VADDR_W-1:0] pc;     // byte address
    inst_cat_t              cat;
    logic                   rd_vld;
    logic [4:0]             rd_idx;
    logic                   rs1_vld;
    logic [4:0]             rs1_idx;
    logic                   rs2_vld;
    logic [4:0]             rs2_idx;
  } disp_t;

endpackage

// File: rtl/frontend_top.sv
`timescale 1ns/1ns
`include "fe_cfg.svh"

module frontend_top (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  input  logic                              i_fetch_vld,
  input  fe_pkg::fetch_blk_t                i_fetch_blk,
  output logic                              o_fetch_rdy,
  output logic                              o_disp_valid,
  output fe_pkg::disp_t [`FE_DISP_SIZE-1:0] o_disp_group,
  input  logic                              i_disp_ready
);

  inst_buffer u_inst_buffer (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_fetch_vld  (i_fetch_vld),
    .i_fetch_blk  (i_fetch_blk),
    .o_fetch_rdy  (o_fetch_rdy),
    .o_disp_valid (o_disp_valid),
    .o_disp_group (o_disp_group),
    .i_disp_ready (i_disp_ready)
  );

endmodule

// File: rtl/inst_buffer.sv
`timescale 1ns/1ns
`include "fe_cfg.svh"

module inst_buffer (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  input  logic                              i_fetch_vld,
  input  fe_pkg::fetch_blk_t                i_fetch_blk,
  output logic                              o_fetch_rdy,
  output logic                              o_disp_valid,
  output fe_pkg::disp_t [`FE_DISP_SIZE-1:0] o_disp_group,
  input  logic                              i_disp_ready
);
  localparam int FW     = `FE_FETCH_WORDS;
  localparam int DW     = `FE_DISP_SIZE;
  localparam int BS     = `FE_BUF_SIZE;
  localparam int POS_W  = $clog2(FW);
  localparam int SUM_W  = POS_W + 1;
  localparam int PTR_W  = $clog2(BS);
  localparam int LEN_W  = $clog2(DW + 1);
  localparam int WIDE_W = 2 * FW;

  fe_pkg::fetch_blk_t r_blk [BS];
  logic [BS-1:0]      r_blk_vld;
  logic [PTR_W-1:0]   w_in_ptr;
  logic [PTR_W-1:0]   w_out_ptr;
  logic [PTR_W-1:0]   w_out_ptr_p1;
  logic               w_fetch_fire;
  logic               w_disp_fire;
  logic               w_pop;

  logic [FW-1:0]      r_issued;     // head block words already sent
  logic [POS_W-1:0]   r_start_pos;  // first unsent word of head block
  logic [WIDE_W-1:0]  w_issued_wide;
  logic               w_head_done;
  logic [LEN_W-1:0]   w_grp_len;
  logic [SUM_W-1:0]   w_pos_next;

  logic [31:0]            w_inst [DW];
  logic [`FE_VADDR_W-1:0] w_pc [DW];
  fe_pkg::inst_cat_t      w_cat [DW];
  logic [DW-1:0]          w_slot_vld;
  logic [DW-1:0]          w_rd_vld;
  logic [DW-1:0]          w_rs1_vld;
  logic [DW-1:0]          w_rs2_vld;
  logic [DW-1:0]          w_disp_mask;

  assign w_fetch_fire = i_fetch_vld & o_fetch_rdy;
  assign w_disp_fire  = o_disp_valid & i_disp_ready;
  assign w_pop        = w_disp_fire & w_head_done;
  assign o_fetch_rdy  = ~(&r_blk_vld);

  queue_ptr #(
    .SIZE (BS)
  ) u_ptr (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_in_vld  (w_fetch_fire),
    .i_out_vld (w_pop),
    .o_in_ptr  (w_in_ptr),
    .o_out_ptr (w_out_ptr)
  );

  assign w_out_ptr_p1 = (w_out_ptr == PTR_W'(BS - 1)) ? '0 : w_out_ptr + 1'b1;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_blk_vld <= '0;
    end else begin
      if (w_fetch_fire) begin
        r_blk_vld[w_in_ptr] <= 1'b1;
      end
      if (w_pop) begin
        r_blk_vld[w_out_ptr] <= 1'b0;  // never the entry being filled
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_fetch_fire) begin
      r_blk[w_in_ptr] <= i_fetch_blk;
    end
  end

  for (genvar k = 0; k < DW; k++) begin : g_slot
    logic [SUM_W-1:0] w_pos;  // msb set once past the head block
    logic [PTR_W-1:0] w_ptr;
    logic [POS_W-1:0] w_word;

    assign w_pos         = {1'b0, r_start_pos} + SUM_W'(k);
    assign w_ptr         = w_pos[POS_W] ? w_out_ptr_p1 : w_out_ptr;
    assign w_word        = w_pos[POS_W-1:0];
    assign w_slot_vld[k] = r_blk_vld[w_ptr];
    assign w_inst[k]     = r_blk[w_ptr].data[32*w_word +: 32];
    assign w_pc[k]       = {r_blk[w_ptr].addr, 2'b00} + (`FE_VADDR_W'(w_word) << 2);

    inst_decode u_dec (
      .i_inst    (w_inst[k]),
      .o_cat     (w_cat[k]),
      .o_rd_vld  (w_rd_vld[k]),
      .o_rs1_vld (w_rs1_vld[k]),
      .o_rs2_vld (w_rs2_vld[k])
    );
  end

  disp_select u_sel (
    .i_slot_vld  (w_slot_vld),
    .i_cat       (w_cat),
    .o_disp_mask (w_disp_mask)
  );

  // low half is the head block, high half the next one
  assign w_issued_wide = {{FW{1'b0}}, r_issued} | (WIDE_W'(w_disp_mask) << r_start_pos);
  assign w_head_done   = &w_issued_wide[FW-1:0];

  always_comb begin
    w_grp_len = '0;
    for (int k = 0; k < DW; k++) begin
      w_grp_len = w_grp_len + LEN_W'(w_disp_mask[k]);
    end
  end

  assign w_pos_next = {1'b0, r_start_pos} + SUM_W'(w_grp_len);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_issued    <= '0;
      r_start_pos <= '0;
    end else if (w_disp_fire) begin
      r_issued    <= w_head_done ? w_issued_wide[WIDE_W-1:FW] : w_issued_wide[FW-1:0];
      r_start_pos <= w_pos_next[POS_W-1:0];  // carries into the next block
    end
  end

  assign o_disp_valid = |w_disp_mask;

  always_comb begin
    for (int k = 0; k < DW; k++) begin
      o_disp_group[k] = '0;
      if (w_disp_mask[k]) begin
        o_disp_group[k].valid   = 1'b1;
        o_disp_group[k].inst    = w_inst[k];
        o_disp_group[k].pc      = w_pc[k];
        o_disp_group[k].cat     = w_cat[k];
        o_disp_group[k].rd_vld  = w_rd_vld[k];
        o_disp_group[k].rd_idx  = w_inst[k][11:7];
        o_disp_group[k].rs1_vld = w_rs1_vld[k];
        o_disp_group[k].rs1_idx = w_inst[k][19:15];
        o_disp_group[k].rs2_vld = w_rs2_vld[k];
        o_disp_group[k].rs2_idx = w_inst[k][24:20];
      end
    end
  end

  // pointer from queue_ptr must land on a free entry
  a_push_free : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_fetch_fire |-> !r_blk_vld[w_in_ptr]);

  // a stalled group holds until it is taken
  a_stall_hold : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_disp_valid && !i_disp_ready) |=> $stable(o_disp_group));

endmodule

// File: rtl/inst_decode.sv
`timescale 1ns/1ns

module inst_decode (
  input  logic [31:0]       i_inst,
  output fe_pkg::inst_cat_t o_cat,
  output logic              o_rd_vld,
  output logic              o_rs1_vld,
  output logic              o_rs2_vld
);
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  opcode_e w_opc;

  assign w_opc = opcode_e'(i_inst[6:0]);

  always_comb begin
    o_cat     = fe_pkg::ILLEGAL;  // unknown opcodes use no registers
    o_rd_vld  = 1'b0;
    o_rs1_vld = 1'b0;
    o_rs2_vld = 1'b0;
    case (w_opc)
      OPC_OP: begin
        o_cat     = fe_pkg::ARITH;
        o_rd_vld  = 1'b1;
        o_rs1_vld = 1'b1;
        o_rs2_vld = 1'b1;
      end
      OPC_OP_IMM, OPC_JALR: begin
        o_cat     = (w_opc == OPC_JALR) ? fe_pkg::BR : fe_pkg::ARITH;
        o_rd_vld  = 1'b1;
        o_rs1_vld = 1'b1;
      end
      OPC_LUI, OPC_AUIPC: begin
        o_cat    = fe_pkg::ARITH;
        o_rd_vld = 1'b1;
      end
      OPC_LOAD: begin
        o_cat     = fe_pkg::LD;
        o_rd_vld  = 1'b1;
        o_rs1_vld = 1'b1;
      end
      OPC_STORE, OPC_BRANCH: begin
        o_cat     = (w_opc == OPC_STORE) ? fe_pkg::ST : fe_pkg::BR;
        o_rs1_vld = 1'b1;
        o_rs2_vld = 1'b1;
      end
      OPC_JAL: begin
        o_cat    = fe_pkg::BR;
        o_rd_vld = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

// File: rtl/queue_ptr.sv
`timescale 1ns/1ns

module queue_ptr #(
  parameter int SIZE = 4
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_in_vld,
  input  logic                    i_out_vld,
  output logic [$clog2(SIZE)-1:0] o_in_ptr,
  output logic [$clog2(SIZE)-1:0] o_out_ptr
);
  localparam int PTR_W = $clog2(SIZE);
  localparam int CNT_W = PTR_W + 1;

  logic [CNT_W-1:0] r_count;  // entries between out and in

  function automatic logic [PTR_W-1:0] wrap_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(SIZE - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_in_ptr  <= '0;
      o_out_ptr <= '0;
      r_count   <= '0;
    end else begin
      if (i_in_vld) begin
        o_in_ptr <= wrap_inc(o_in_ptr);
      end
      if (i_out_vld) begin
        o_out_ptr <= wrap_inc(o_out_ptr);
      end
      r_count <= r_count + CNT_W'(i_in_vld) - CNT_W'(i_out_vld);
    end
  end

  // out may not overtake in, and in may not lap out
  a_no_pass : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_out_vld && !i_in_vld && r_count == '0) &&
    !(i_in_vld && !i_out_vld && r_count == CNT_W'(SIZE)));

endmodule

// File: sim.f
+incdir+rtl
rtl/fe_pkg.sv
rtl/queue_ptr.sv
rtl/inst_decode.sv
rtl/disp_select.sv
rtl/inst_buffer.sv
rtl/frontend_top.sv
tests/tb_clk_gen.sv
tests/tb_frontend.sv

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset_n <= 1'b1;  // released on an edge
  end

endmodule

// File: tests/tb_frontend.sv
`timescale 1ns/1ns
`include "fe_cfg.svh"

module tb_frontend;
  localparam int N_BLKS   = 10;
  localparam int N_GRPS   = 15;
  localparam int N_PHASES = 5;
  localparam int TIMEOUT  = N_GRPS * 20 + 200;

  localparam logic [6:0] OPC_OP = 7'h33, OPC_IMM = 7'h13, OPC_LUI = 7'h37;
  localparam logic [6:0] OPC_LOAD = 7'h03, OPC_STORE = 7'h23, OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JAL = 7'h6f, OPC_JALR = 7'h67, OPC_BAD = 7'h00;

  // expected decode per slot, category then rd, rs1, rs2 valid
  localparam logic [5:0] D_OP   = {fe_pkg::ARITH, 3'b111};
  localparam logic [5:0] D_IMM  = {fe_pkg::ARITH, 3'b110};
  localparam logic [5:0] D_UI   = {fe_pkg::ARITH, 3'b100};
  localparam logic [5:0] D_LD   = {fe_pkg::LD, 3'b110};
  localparam logic [5:0] D_ST   = {fe_pkg::ST, 3'b011};
  localparam logic [5:0] D_BR   = {fe_pkg::BR, 3'b011};
  localparam logic [5:0] D_JAL  = {fe_pkg::BR, 3'b100};
  localparam logic [5:0] D_JALR = {fe_pkg::BR, 3'b110};
  localparam logic [5:0] D_ILL  = {fe_pkg::ILLEGAL, 3'b000};
  localparam logic [5:0] D_NONE = 6'd0;

  logic                              i_clk;
  logic                              i_reset_n;
  logic                              i_fetch_vld = 1'b0;
  fe_pkg::fetch_blk_t                i_fetch_blk = '0;
  logic                              o_fetch_rdy;
  logic                              o_disp_valid;
  fe_pkg::disp_t [`FE_DISP_SIZE-1:0] o_disp_group;
  logic                              i_disp_ready = 1'b0;

  logic [31:0] blk_pc [N_BLKS];
  logic [31:0] blk_word [N_BLKS][4];
  logic [2:0]  exp_len [N_GRPS];
  logic [31:0] exp_pc [N_GRPS];
  logic [5:0]  exp_dec [N_GRPS][4];
  string       ph_name [N_PHASES];
  int          ph_blks [N_PHASES];
  int          ph_grps [N_PHASES];
  bit          ph_full [N_PHASES];

  int n_blk = 0;
  int n_grp = 0;
  int n_ph = 0;
  int blk_next = 0;
  int grp_end = 0;
  int grp_idx = 0;
  int err_cnt = 0;
  int test_err = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int cycles = 0;
  string cur_name = "reset_idle";
  bit drain_en = 1'b0;
  bit was_stalled = 1'b0;
  logic [31:0] rng = 32'd79;
  fe_pkg::disp_t [`FE_DISP_SIZE-1:0] held_group;

  tb_clk_gen #(.PERIOD(8), .RESET_CYCLES(5)) u_clk_gen (
    .o_clk     (i_clk),
    .o_reset_n (i_reset_n)
  );

  frontend_top i_dut (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_fetch_vld  (i_fetch_vld),
    .i_fetch_blk  (i_fetch_blk),
    .o_fetch_rdy  (o_fetch_rdy),
    .o_disp_valid (o_disp_valid),
    .o_disp_group (o_disp_group),
    .i_disp_ready (i_disp_ready)
  );

  function automatic logic [31:0] enc(input logic [6:0] opc, input int rd, input int rs1,
                                      input int rs2);
    return {7'd0, 5'(rs2), 5'(rs1), 3'd0, 5'(rd), opc};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] pc);
    for (int b = 0; b < n_blk; b++) begin
      if (blk_pc[b][31:4] == pc[31:4]) return blk_word[b][pc[3:2]];
    end
    return 32'd0;
  endfunction

  function automatic fe_pkg::disp_t expect_slot(input logic [31:0] pc, input logic [5:0] dec);
    fe_pkg::disp_t s;
    logic [31:0]   w;
    w         = word_at(pc);
    s         = '0;
    s.valid   = 1'b1;
    s.inst    = w;
    s.pc      = pc;
    s.cat     = fe_pkg::inst_cat_t'(dec[5:3]);
    s.rd_vld  = dec[2];
    s.rd_idx  = w[11:7];
    s.rs1_vld = dec[1];
    s.rs1_idx = w[19:15];
    s.rs2_vld = dec[0];
    s.rs2_idx = w[24:20];
    return s;
  endfunction

  task automatic add_block(input logic [31:0] pc, input logic [31:0] w0, input logic [31:0] w1,
                           input logic [31:0] w2, input logic [31:0] w3);
    blk_pc[n_blk] = pc;
    blk_word[n_blk] = '{w0, w1, w2, w3};
    n_blk++;
  endtask

  task automatic add_group(input int len, input logic [31:0] pc, input logic [5:0] d0,
                           input logic [5:0] d1, input logic [5:0] d2, input logic [5:0] d3);
    exp_len[n_grp] = 3'(len);
    exp_pc[n_grp]  = pc;
    exp_dec[n_grp] = '{d0, d1, d2, d3};
    n_grp++;
  endtask

  task automatic add_phase(input string name, input int blks, input int grps, input bit full);
    ph_name[n_ph] = name;
    ph_blks[n_ph] = blks;
    ph_grps[n_ph] = grps;
    ph_full[n_ph] = full;
    n_ph++;
  endtask

  task automatic load_tables();
    add_phase("arith_pairs", 1, 2, 1'b0);
    add_block(32'h1000, enc(OPC_OP, 1, 2, 3), enc(OPC_IMM, 4, 5, 0), enc(OPC_OP, 6, 7, 8),
              enc(OPC_OP, 9, 10, 11));
    add_group(2, 32'h1000, D_OP, D_IMM, D_NONE, D_NONE);
    add_group(2, 32'h1008, D_OP, D_OP, D_NONE, D_NONE);
    add_phase("quota_split", 1, 2, 1'b0);
    add_block(32'h2000, enc(OPC_LOAD, 1, 2, 0), enc(OPC_STORE, 0, 4, 3),
              enc(OPC_BRANCH, 0, 5, 6), enc(OPC_OP, 7, 8, 9));
    add_group(1, 32'h2000, D_LD, D_NONE, D_NONE, D_NONE);
    add_group(3, 32'h2004, D_ST, D_BR, D_OP, D_NONE);
    add_phase("cross_block", 2, 3, 1'b0);
    add_block(32'h3000, enc(OPC_OP, 1, 2, 3), enc(OPC_OP, 2, 3, 4), enc(OPC_IMM, 3, 4, 0),
              enc(OPC_LOAD, 4, 5, 0));
    add_block(32'h3010, enc(OPC_OP, 5, 6, 7), enc(OPC_BRANCH, 0, 6, 7),
              enc(OPC_STORE, 0, 8, 9), enc(OPC_OP, 10, 11, 12));
    add_group(2, 32'h3000, D_OP, D_OP, D_NONE, D_NONE);
    add_group(4, 32'h3008, D_IMM, D_LD, D_OP, D_BR);  // spans both blocks
    add_group(2, 32'h3018, D_ST, D_OP, D_NONE, D_NONE);
    add_phase("full_stall", 4, 5, 1'b1);
    add_block(32'h4000, enc(OPC_OP, 1, 2, 3), enc(OPC_OP, 2, 3, 4), enc(OPC_OP, 3, 4, 5),
              enc(OPC_OP, 4, 5, 6));
    add_block(32'h4010, enc(OPC_LOAD, 5, 1, 0), enc(OPC_LOAD, 6, 2, 0),
              enc(OPC_BRANCH, 0, 3, 4), enc(OPC_OP, 7, 8, 9));
    add_block(32'h4020, enc(OPC_OP, 10, 11, 12), enc(OPC_STORE, 0, 13, 14),
              enc(OPC_OP, 15, 16, 17), enc(OPC_OP, 18, 19, 20));
    add_block(32'h4030, enc(OPC_BRANCH, 0, 21, 22), enc(OPC_OP, 23, 24, 25),
              enc(OPC_LOAD, 26, 27, 0), enc(OPC_OP, 28, 29, 30));
    add_group(2, 32'h4000, D_OP, D_OP, D_NONE, D_NONE);
    add_group(3, 32'h4008, D_OP, D_OP, D_LD, D_NONE);
    add_group(4, 32'h4014, D_LD, D_BR, D_OP, D_OP);
    add_group(4, 32'h4024, D_ST, D_OP, D_OP, D_BR);
    add_group(3, 32'h4034, D_OP, D_LD, D_OP, D_NONE);
    add_phase("decode_corners", 2, 3, 1'b0);
    add_block(32'h5000, enc(OPC_LUI, 10, 0, 0), enc(OPC_JAL, 1, 0, 0),
              enc(OPC_STORE, 0, 2, 3), enc(OPC_BAD, 5, 6, 7));
    add_block(32'h5010, enc(OPC_BAD, 8, 9, 10), enc(OPC_OP, 11, 12, 13),
              enc(OPC_OP, 14, 15, 16), enc(OPC_JALR, 17, 18, 0));
    add_group(4, 32'h5000, D_UI, D_JAL, D_ST, D_ILL);
    add_group(2, 32'h5010, D_ILL, D_OP, D_NONE, D_NONE);  // illegal fills an arith slot
    add_group(2, 32'h5018, D_OP, D_JALR, D_NONE, D_NONE);
  endtask

  task automatic count_error();
    err_cnt++;
    test_err++;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_err != 0) tests_bad++;
    $display("%s: %s", cur_name, (test_err == 0) ? "ok" : "FAIL");
  endtask

  task automatic check_group();
    fe_pkg::disp_t exp;
    logic [31:0]   pc;
    assert (grp_idx < n_grp) else begin
      $display("%s: a group was dispatched after all expected groups", cur_name);
      count_error();
    end
    if (grp_idx < n_grp) begin
      for (int k = 0; k < `FE_DISP_SIZE; k++) begin
        pc  = exp_pc[grp_idx] + 32'(4 * k);
        exp = (k < exp_len[grp_idx]) ? expect_slot(pc, exp_dec[grp_idx][k]) : '0;
        assert (o_disp_group[k] == exp) else begin
          $display("Mismatch %s group %0d slot %0d: expected %h, actual %h", cur_name, grp_idx,
                   k, exp, o_disp_group[k]);
          count_error();
        end
      end
    end
    grp_idx++;
  endtask

  task automatic push_block(input int b);
    fe_pkg::fetch_blk_t blk;
    blk.addr = blk_pc[b][31:2];
    blk.data = {blk_word[b][3], blk_word[b][2], blk_word[b][1], blk_word[b][0]};
    @(posedge i_clk);
    i_fetch_vld <= 1'b1;
    i_fetch_blk <= blk;
    @(negedge i_clk);
    while (!o_fetch_rdy) @(negedge i_clk);
    @(posedge i_clk);  // accepted here
    i_fetch_vld <= 1'b0;
  endtask

  task automatic run_phase(input int p);
    test_err = 0;
    cur_name = ph_name[p];
    grp_end  = grp_end + ph_grps[p];
    for (int b = 0; b < ph_blks[p]; b++) begin
      push_block(blk_next);
      blk_next++;
    end
    if (ph_full[p]) begin
      @(negedge i_clk);
      assert (!o_fetch_rdy) else begin
        $display("%s: fetch ready stayed high with every buffer entry in use", cur_name);
        count_error();
      end
      repeat (8) @(posedge i_clk);  // stalled window
    end
    @(posedge i_clk);
    drain_en <= 1'b1;
    wait (grp_idx == grp_end);
    @(posedge i_clk);
    drain_en <= 1'b0;
    @(negedge i_clk);
    assert (!o_disp_valid) else begin
      $display("%s: instructions still offered after the last expected group", cur_name);
      count_error();
    end
    finish_test();
  endtask

  // random back-pressure while draining
  always @(posedge i_clk) begin
    rng = xorshift32(rng);
    i_disp_ready <= drain_en && (rng[1:0] != 2'b00);
  end

  always @(negedge i_clk) begin
    if (i_reset_n === 1'b1) begin
      if (was_stalled) begin
        assert (o_disp_group == held_group) else begin
          $display("%s: group changed while dispatch was stalled", cur_name);
          count_error();
        end
      end
      was_stalled = o_disp_valid && !i_disp_ready;
      held_group  = o_disp_group;
      if (o_disp_valid && i_disp_ready) check_group();  // taken on the next edge
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, dispatch stalled at group %0d of %0d", cycles,
               grp_idx, N_GRPS);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    load_tables();
    wait (i_reset_n === 1'b1);
    @(negedge i_clk);
    assert (!o_disp_valid && o_fetch_rdy && o_disp_group == '0) else begin
      $display("%s: dispatch port not idle after reset, valid=%b rdy=%b", cur_name,
               o_disp_valid, o_fetch_rdy);
      count_error();
    end
    finish_test();
    for (int p = 0; p < n_ph; p++) begin
      run_phase(p);
    end
    $display("%0d tests run, %0d failing, %0d check errors", tests_run, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
